//--- design/imuldiv_pkg.sv
// --------------------------------------------------
// shared width, function codes and result layout
// for the iterative multiply/divide unit
// --------------------------------------------------
`default_nettype none

package imuldiv_pkg;

  // operand width of the processor datapath
  localparam int xlen = 32;

  // request function codes
  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } muldiv_fn_t;

  // divide result view
  // remainder sits in the upper half, quotient in the lower half
  typedef struct packed {
    logic [xlen-1:0] rem;
    logic [xlen-1:0] quot;
  } div_result_t;

  // one 64-bit response word, read as a product or as rem/quot
  typedef union packed {
    logic [2*xlen-1:0] product;
    div_result_t       div;
  } muldiv_result_u;

endpackage

`default_nettype wire

//--- design/div_ctrl_if.sv
// --------------------------------------------------
// control and status between divider FSM and datapath
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface div_ctrl_if;

  // control, driven by the FSM
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic is_signed;

  // status, driven by the datapath
  logic sub_neg;
  logic counter_is_zero;

  modport ctrl (
    output a_en, b_en, a_mux_sel, sub_mux_sel, cntr_mux_sel, sign_en, is_signed,
    input  sub_neg, counter_is_zero
  );

  modport dpath (
    input  a_en, b_en, a_mux_sel, sub_mux_sel, cntr_mux_sel, sign_en, is_signed,
    output sub_neg, counter_is_zero
  );

endinterface

`default_nettype wire

//--- design/int_div_dpath.sv
// --------------------------------------------------
// divider datapath: operand magnitudes, restoring
// shift-subtract step, step counter, sign fixup
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module int_div_dpath
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  output muldiv_result_u  resp_result,
  div_ctrl_if.dpath       ctl
);

  // combined remainder/quotient width, one guard bit on top
  localparam int rq_w = 2 * xlen + 1;
  localparam logic [4:0] last_step = 5'(xlen - 1);

  logic [rq_w-1:0] a_reg;
  logic [rq_w-1:0] b_reg;
  logic [4:0]      counter_reg;
  logic            quot_sign_reg;
  logic            rem_sign_reg;

  logic [xlen-1:0] a_mag;
  logic [xlen-1:0] b_mag;
  logic [rq_w-1:0] a_initial;
  logic [rq_w-1:0] b_initial;
  logic [rq_w-1:0] a_shift;
  logic [rq_w-1:0] sub_out;
  logic [rq_w-1:0] sub_keep;
  logic [rq_w-1:0] sub_restore;
  logic [rq_w-1:0] sub_mux_out;
  logic [rq_w-1:0] a_mux_out;
  logic [4:0]      counter_next;
  logic [xlen-1:0] quot_raw;
  logic [xlen-1:0] rem_raw;

  // --------------------------------------------------
  // operand setup
  // --------------------------------------------------

  // magnitudes only for signed divide
  assign a_mag = (ctl.is_signed && a[xlen-1]) ? -a : a;
  assign b_mag = (ctl.is_signed && b[xlen-1]) ? -b : b;

  // dividend starts in the low half
  assign a_initial = {{(xlen+1){1'b0}}, a_mag};
  // divisor lines up with the upper half
  assign b_initial = {1'b0, b_mag, {xlen{1'b0}}};

  // --------------------------------------------------
  // one restoring step
  // --------------------------------------------------
  assign a_shift = {a_reg[rq_w-2:0], 1'b0};
  assign sub_out = a_shift - b_reg;

  // guard bit set means the trial went negative
  assign ctl.sub_neg = sub_out[rq_w-1];

  // keep the difference and shift in a quotient one
  assign sub_keep    = {sub_out[rq_w-1:1], 1'b1};
  // otherwise fall back to the shifted value with a zero
  assign sub_restore = {a_shift[rq_w-1:1], 1'b0};

  assign sub_mux_out = ctl.sub_mux_sel ? sub_restore : sub_keep;
  assign a_mux_out   = ctl.a_mux_sel ? sub_mux_out : a_initial;

  // step counter, preloaded unless decrementing
  assign counter_next        = ctl.cntr_mux_sel ? counter_reg - 5'd1 : last_step;
  assign ctl.counter_is_zero = (counter_reg == 5'd0);

  // payload registers
  always_ff @(posedge clk) begin
    if (ctl.a_en) begin
      a_reg <= a_mux_out;
    end
    if (ctl.b_en) begin
      b_reg <= b_initial;
    end
  end

  // counter and sign flags
  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg   <= 5'd0;
      quot_sign_reg <= 1'b0;
      rem_sign_reg  <= 1'b0;
    end else begin
      counter_reg <= counter_next;
      if (ctl.sign_en) begin
        // quotient negative when operand signs differ
        quot_sign_reg <= ctl.is_signed & (a[xlen-1] ^ b[xlen-1]);
        // remainder follows the dividend
        rem_sign_reg  <= ctl.is_signed & a[xlen-1];
      end
    end
  end

  // --------------------------------------------------
  // sign correction on the way out
  // --------------------------------------------------
  assign quot_raw = a_reg[xlen-1:0];
  assign rem_raw  = a_reg[2*xlen-1:xlen];

  always_comb begin
    resp_result.div.quot = quot_sign_reg ? -quot_raw : quot_raw;
    resp_result.div.rem  = rem_sign_reg ? -rem_raw : rem_raw;
  end

endmodule

`default_nettype wire

//--- design/int_div_ctrl.sv
// --------------------------------------------------
// divider control FSM and its val/rdy handshake
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module int_div_ctrl
  import imuldiv_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  muldiv_fn_t fn,
  input  logic       req_val,
  output logic       req_rdy,
  output logic       resp_val,
  input  logic       resp_rdy,
  div_ctrl_if.ctrl   ctl
);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  state_t state;
  logic   req_go;
  logic   resp_go;

  // request taken in idle
  assign req_go  = (state == st_idle) && req_val;
  // response taken in done
  assign resp_go = (state == st_done) && resp_rdy;

  // only the signed divide works on magnitudes
  assign ctl.is_signed = (fn == fn_div);

  // --------------------------------------------------
  // state register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
          end
        end
        st_calc: begin
          // last step runs while the counter reads zero
          if (ctl.counter_is_zero) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // outputs decoded from state
  // --------------------------------------------------
  always_comb begin
    req_rdy          = 1'b0;
    resp_val         = 1'b0;
    ctl.a_en         = 1'b0;
    ctl.b_en         = 1'b0;
    ctl.a_mux_sel    = 1'b0;
    ctl.sub_mux_sel  = 1'b0;
    ctl.cntr_mux_sel = 1'b0;
    ctl.sign_en      = 1'b0;
    case (state)
      st_idle: begin
        req_rdy     = 1'b1;
        // load operands and signs on acceptance
        ctl.a_en    = req_go;
        ctl.b_en    = req_go;
        ctl.sign_en = req_go;
      end
      st_calc: begin
        ctl.a_en         = 1'b1;
        ctl.a_mux_sel    = 1'b1;
        // restore when the trial subtraction went negative
        ctl.sub_mux_sel  = ctl.sub_neg;
        ctl.cntr_mux_sel = 1'b1;
      end
      st_done: begin
        resp_val = 1'b1;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/int_div_iterative.sv
// --------------------------------------------------
// iterative divider, control FSM plus datapath
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module int_div_iterative
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  muldiv_fn_t      fn,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  logic            req_val,
  output logic            req_rdy,
  output muldiv_result_u  resp_result,
  output logic            resp_val,
  input  logic            resp_rdy
);

  // control and status bundle
  div_ctrl_if ctl_if ();

  int_div_ctrl ctrl_i (
    .clk      (clk),
    .reset    (reset),
    .fn       (fn),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctl      (ctl_if.ctrl)
  );

  int_div_dpath dpath_i (
    .clk         (clk),
    .reset       (reset),
    .a           (a),
    .b           (b),
    .resp_result (resp_result),
    .ctl         (ctl_if.dpath)
  );

endmodule

`default_nettype wire

//--- design/int_mul_iterative.sv
// --------------------------------------------------
// iterative signed shift-and-add multiplier
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module int_mul_iterative
  import imuldiv_pkg::*;
(
  input  logic            clk,
  input  logic            reset,
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  logic            req_val,
  output logic            req_rdy,
  output muldiv_result_u  resp_result,
  output logic            resp_val,
  input  logic            resp_rdy
);

  localparam logic [4:0] last_step = 5'(xlen - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_calc,
    st_done
  } state_t;

  state_t            state;
  logic [2*xlen-1:0] mcand_reg;
  logic [xlen-1:0]   mplier_reg;
  logic [2*xlen-1:0] acc_reg;
  logic [4:0]        counter_reg;
  logic              sign_reg;

  logic req_go;
  logic resp_go;

  assign req_go  = (state == st_idle) && req_val;
  assign resp_go = (state == st_done) && resp_rdy;

  assign req_rdy  = (state == st_idle);
  assign resp_val = (state == st_done);

  // --------------------------------------------------
  // FSM
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (req_go) begin
            state <= st_calc;
          end
        end
        st_calc: begin
          if (counter_reg == 5'd0) begin
            state <= st_done;
          end
        end
        st_done: begin
          if (resp_go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // --------------------------------------------------
  // shift-and-add datapath
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (req_go) begin
      // work on magnitudes, keep the product sign aside
      mcand_reg   <= {{xlen{1'b0}}, a[xlen-1] ? -a : a};
      mplier_reg  <= b[xlen-1] ? -b : b;
      acc_reg     <= '0;
      counter_reg <= last_step;
      sign_reg    <= a[xlen-1] ^ b[xlen-1];
    end else if (state == st_calc) begin
      // add the multiplicand for each set multiplier bit
      if (mplier_reg[0]) begin
        acc_reg <= acc_reg + mcand_reg;
      end
      mcand_reg   <= {mcand_reg[2*xlen-2:0], 1'b0};
      mplier_reg  <= {1'b0, mplier_reg[xlen-1:1]};
      counter_reg <= counter_reg - 5'd1;
    end
  end

  // negate the magnitude product when the signs differed
  always_comb begin
    resp_result.product = sign_reg ? -acc_reg : acc_reg;
  end

endmodule

`default_nettype wire

//--- design/int_muldiv_iterative.sv
// --------------------------------------------------
// multiply/divide top, steers requests by function
// code and returns the active unit's response
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module int_muldiv_iterative
  import imuldiv_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  muldiv_fn_t        req_fn,
  input  logic [xlen-1:0]   req_a,
  input  logic [xlen-1:0]   req_b,
  input  logic              req_val,
  output logic              req_rdy,
  output logic [2*xlen-1:0] resp_result,
  output logic              resp_val,
  input  logic              resp_rdy
);

  // one operation outstanding at a time
  logic busy;
  // high while the divider owns the operation
  logic active_div;
  logic pick_div;

  logic           div_req_val;
  logic           div_req_rdy;
  muldiv_result_u div_result;
  logic           div_resp_val;
  logic           mul_req_val;
  logic           mul_req_rdy;
  muldiv_result_u mul_result;
  logic           mul_resp_val;

  // anything other than multiply goes to the divider
  assign pick_div = (req_fn != fn_mul);

  assign req_rdy     = !busy && div_req_rdy && mul_req_rdy;
  assign div_req_val = req_val && req_rdy && pick_div;
  assign mul_req_val = req_val && req_rdy && !pick_div;

  // response from the unit that owns the operation
  assign resp_val    = active_div ? div_resp_val : mul_resp_val;
  assign resp_result = active_div ? div_result : mul_result;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy       <= 1'b0;
      active_div <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy       <= 1'b1;
      active_div <= pick_div;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

  int_div_iterative div_i (
    .clk         (clk),
    .reset       (reset),
    .fn          (req_fn),
    .a           (req_a),
    .b           (req_b),
    .req_val     (div_req_val),
    .req_rdy     (div_req_rdy),
    .resp_result (div_result),
    .resp_val    (div_resp_val),
    .resp_rdy    (resp_rdy && active_div)
  );

  int_mul_iterative mul_i (
    .clk         (clk),
    .reset       (reset),
    .a           (req_a),
    .b           (req_b),
    .req_val     (mul_req_val),
    .req_rdy     (mul_req_rdy),
    .resp_result (mul_result),
    .resp_val    (mul_resp_val),
    .resp_rdy    (resp_rdy && !active_div)
  );

endmodule

`default_nettype wire

//--- tb/int_muldiv_tb.sv
// --------------------------------------------------
// testbench for the iterative multiply/divide unit
// lfsr stimulus, reference model, in-order compare
// --------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module int_muldiv_tb
  import imuldiv_pkg::*;
;

  localparam int num_directed = 9;
  localparam int num_random   = 80;
  localparam int total_reqs   = num_directed + num_random;
  localparam int wait_limit   = 200;

  logic        clk;
  logic        reset;
  muldiv_fn_t  req_fn;
  logic [31:0] req_a;
  logic [31:0] req_b;
  logic        req_val;
  logic        req_rdy;
  logic [63:0] resp_result;
  logic        resp_val;
  logic        resp_rdy;

  // accepted requests waiting for their response
  muldiv_fn_t  fn_q[$];
  logic [31:0] a_q[$];
  logic [31:0] b_q[$];

  logic [15:0] lfsr_state;
  int          errors;
  int          checks;
  logic        aborted;

  int_muldiv_iterative int_muldiv_iterative_i (
    .clk         (clk),
    .reset       (reset),
    .req_fn      (req_fn),
    .req_a       (req_a),
    .req_b       (req_b),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // random bits and reference model
  // --------------------------------------------------
  // 16-bit galois lfsr with taps for x^16+x^14+x^13+x^11+1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // expected response word for one request
  function automatic muldiv_result_u expected_result(input muldiv_fn_t fn,
                                                     input logic [31:0] a,
                                                     input logic [31:0] b);
    muldiv_result_u    r;
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic [31:0]        a_mag;
    logic [31:0]        b_mag;
    logic [31:0]        q;
    logic [31:0]        rm;
    logic               signed_div;
    r = '0;
    if (fn == fn_mul) begin
      sa = {{32{a[31]}}, a};
      sb = {{32{b[31]}}, b};
      r.product = sa * sb;
    end else begin
      signed_div = (fn == fn_div);
      a_mag = (signed_div && a[31]) ? -a : a;
      b_mag = (signed_div && b[31]) ? -b : b;
      // divide by zero gives all ones and keeps the dividend
      if (b_mag == 32'd0) begin
        q  = '1;
        rm = a_mag;
      end else begin
        q  = a_mag / b_mag;
        rm = a_mag % b_mag;
      end
      // quotient sign from operand parity and remainder sign from the dividend
      r.div.quot = (signed_div && (a[31] ^ b[31])) ? -q : q;
      r.div.rem  = (signed_div && a[31]) ? -rm : rm;
    end
    return r;
  endfunction

  task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                             input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("CHECK FAILED at %0t: %s (got %h, expected %h)", $time, msg, actual, expected);
    end
  endtask

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  // called just after a rising edge and returns just after one
  task automatic send_request(input muldiv_fn_t fn, input logic [31:0] a,
                              input logic [31:0] b);
    int waited;
    if (!aborted) begin
      req_fn  = fn;
      req_a   = a;
      req_b   = b;
      req_val = 1'b1;
      waited  = 0;
      @(negedge clk);
      while (!req_rdy && waited < wait_limit) begin
        @(negedge clk);
        waited++;
      end
      if (!req_rdy) begin
        $display("timeout at %0t: the DUT never accepted a request", $time);
        errors++;
        aborted = 1'b1;
      end else begin
        fn_q.push_back(fn);
        a_q.push_back(a);
        b_q.push_back(b);
      end
      @(posedge clk);
      #1;
      req_val = 1'b0;
    end
  endtask

  task automatic send_requests();
    muldiv_fn_t  fn;
    logic [31:0] r;
    logic [31:0] a;
    logic [31:0] b;
    int          n;
    // divide by zero, wrap and sign corners
    send_request(fn_div,  32'h0000_1234, 32'h0000_0000);
    send_request(fn_div,  32'hffff_f000, 32'h0000_0000);
    send_request(fn_divu, 32'h8765_4321, 32'h0000_0000);
    send_request(fn_div,  32'h8000_0000, 32'hffff_ffff);
    send_request(fn_divu, 32'h8000_0000, 32'hffff_ffff);
    send_request(fn_mul,  32'h0000_0000, 32'hdead_beef);
    send_request(fn_mul,  32'h8000_0000, 32'h8000_0000);
    send_request(fn_mul,  32'hffff_ffff, 32'hffff_ffff);
    send_request(fn_div,  32'hffff_fff9, 32'h0000_0002);
    // mixed random traffic issued back to back
    for (n = 0; n < num_random; n++) begin
      random_bits(2, r);
      case (r[1:0])
        2'd1:    fn = fn_div;
        2'd2:    fn = fn_divu;
        default: fn = fn_mul;
      endcase
      random_bits(32, a);
      random_bits(32, b);
      random_bits(2, r);
      case (r[1:0])
        // small divisor of either sign including zero
        2'd0: b = {{28{b[3]}}, b[3:0]};
        // most-negative dividend
        2'd1: a = 32'h8000_0000;
        // most-negative divisor
        2'd2: b = 32'h8000_0000;
        default: ;
      endcase
      send_request(fn, a, b);
    end
  endtask

  // --------------------------------------------------
  // response side with random back-pressure
  // --------------------------------------------------
  task automatic collect_responses();
    int             got;
    int             waited;
    int             hold;
    logic [31:0]    r;
    logic [63:0]    held;
    muldiv_result_u exp;
    muldiv_fn_t     fn;
    logic [31:0]    a;
    logic [31:0]    b;
    got = 0;
    while (got < total_reqs && !aborted) begin
      waited = 0;
      @(negedge clk);
      while (!resp_val && waited < wait_limit) begin
        @(negedge clk);
        waited++;
      end
      if (!resp_val) begin
        $display("timeout at %0t: a response never arrived", $time);
        errors++;
        aborted = 1'b1;
      end else if (fn_q.size() == 0) begin
        $display("error at %0t: response arrived with no request outstanding", $time);
        errors++;
        aborted = 1'b1;
      end else begin
        held = resp_result;
        check_value(64'(req_rdy), 64'd0, "req_rdy high while a response is pending");
        random_bits(3, r);
        hold = int'(r);
        // result and valid must hold while resp_rdy is low
        repeat (hold) begin
          @(negedge clk);
          check_value(64'(resp_val), 64'd1, "resp_val dropped during back-pressure");
          check_value(resp_result, held, "resp_result changed during back-pressure");
          check_value(64'(req_rdy), 64'd0, "req_rdy rose during back-pressure");
        end
        @(posedge clk);
        #1;
        resp_rdy = 1'b1;
        @(negedge clk);
        check_value(64'(resp_val), 64'd1, "resp_val low at the transfer");
        fn  = fn_q.pop_front();
        a   = a_q.pop_front();
        b   = b_q.pop_front();
        exp = expected_result(fn, a, b);
        check_value(resp_result, exp.product,
                    $sformatf("result for fn %0d a %h b %h", fn, a, b));
        @(posedge clk);
        #1;
        resp_rdy = 1'b0;
        got++;
      end
    end
  endtask

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    req_fn     = fn_mul;
    req_a      = '0;
    req_b      = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    lfsr_state = 16'd39115;
    errors     = 0;
    checks     = 0;
    aborted    = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_value(64'(req_rdy), 64'd1, "req_rdy low after reset");
    check_value(64'(resp_val), 64'd0, "resp_val high after reset");
    @(posedge clk);
    #1;
    fork
      send_requests();
      collect_responses();
    join
    // no stray response after the last transfer
    @(negedge clk);
    check_value(64'(resp_val), 64'd0, "resp_val high after the last transfer");
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
design/imuldiv_pkg.sv
design/div_ctrl_if.sv
design/int_div_dpath.sv
design/int_div_ctrl.sv
design/int_div_iterative.sv
design/int_mul_iterative.sv
design/int_muldiv_iterative.sv
tb/int_muldiv_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the multiply/divide testbench with Verilator and run it
# the run passes only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv --top-module int_muldiv_tb -f project.f \
  -o int_muldiv_sim || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/int_muldiv_sim 2>&1)"
printf '%s\n' "$sim_out"
grep -q "SIMULATION PASSED" <<< "$sim_out" && exit 0 || exit 1
